// ==== compile.f ====
+incdir+.
csr_pkg.sv
trap_pkg.sv
csr_file.sv
irq_prioritizer.sv
trap_control.sv
trap_unit_top.sv
tb_trap_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the trap unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_trap_unit \
    -f compile.f \
    --Mdir obj_dir \
    -o tb_trap_unit

# A $fatal in the testbench gives a failing exit status here.
./obj_dir/tb_trap_unit

// ==== tb_trap_unit_tasks.svh ====
// Trap unit testbench tasks with stimulus drivers, typed compare tasks and directed tests.
`ifndef TB_TRAP_UNIT_TASKS_SVH
`define TB_TRAP_UNIT_TASKS_SVH

// Prints the reason and the fail line, then stops.
task automatic stop_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
endtask

task automatic check_word(input word_t got, input word_t exp, input string msg);
    if (got !== exp)
        stop_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp));
endtask

task automatic check_cause(input cause_t got, input cause_t exp, input string msg);
    if (got !== exp)
        stop_run($sformatf("mismatch at %0t ns: %s, got %0d, expected %0d", $time, msg, got, exp));
endtask

task automatic check_pc(input pc_t got, input pc_t exp, input string msg);
    if (got !== exp)
        stop_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h", $time, msg,
                           {got, 1'b0}, {exp, 1'b0}));
endtask

task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp)
        stop_run($sformatf("mismatch at %0t ns: %s, got %b, expected %b", $time, msg, got, exp));
endtask

task automatic check_exc(input exception_t got, input exception_t exp, input string msg);
    if (got !== exp)
        stop_run($sformatf({"mismatch at %0t ns: %s, got take=%b irq=%b cause=%0d tvec=%h,",
                            " expected take=%b irq=%b cause=%0d tvec=%h"}, $time, msg,
                           got.take, got.is_irq, got.cause, got.tvec,
                           exp.take, exp.is_irq, exp.cause, exp.tvec));
endtask

// Quiet CSR, retire and MRET inputs from the next edge.
task automatic drive_idle();
    @(posedge clk);
    csr_req    <= '0;
    retire     <= '0;
    mret_valid <= 1'b0;
endtask

// One write cycle; the value lands at the following edge.
task automatic csr_write(input csr_addr_t csr_addr, input word_t data);
    @(posedge clk);
    csr_req <= '{we: 1'b1, addr: csr_addr, wdata: data};
    @(posedge clk);
    csr_req <= '0;
endtask

// Combinational response sampled mid-cycle.
task automatic csr_read(input csr_addr_t csr_addr, output csr_rsp_t rsp);
    @(posedge clk);
    csr_req <= '{we: 1'b0, addr: csr_addr, wdata: 32'h0};
    @(negedge clk);
    rsp = csr_rsp;
endtask

task automatic expect_csr(input csr_addr_t csr_addr, input word_t exp, input string msg);
    csr_rsp_t rsp;
    csr_read(csr_addr, rsp);
    check_bit(rsp.exists, 1'b1, msg);
    check_word(rsp.rdata, exp, msg);
endtask

// Lowest set cause above 0 or 0 when none is set.
function automatic cause_t lowest_cause(input irq_vec_t vec);
    for (int i = 1; i < 32; i++) begin
        if (vec[i])
            return cause_t'(i);
    end
    return '0;
endfunction

task automatic csr_access();
    csr_rsp_t rsp;
    csr_write(CSR_MSCRATCH, 32'hdead_beef);
    expect_csr(CSR_MSCRATCH, 32'hdead_beef, "mscratch readback");
    csr_write(CSR_MIE, 32'ha5a5_5a5a);
    expect_csr(CSR_MIE, 32'ha5a5_5a5a, "mie readback");
    // Alignment bits read back as zero.
    csr_write(CSR_MTVEC, 32'h1234_567b);
    expect_csr(CSR_MTVEC, 32'h1234_5678, "mtvec low bits");
    csr_write(CSR_MEPC, 32'h8000_0103);
    expect_csr(CSR_MEPC, 32'h8000_0102, "mepc bit 0");
    // RV32 with I, M and C.
    expect_csr(CSR_MISA, 32'h4000_1104, "misa");
    expect_csr(CSR_MARCHID, 32'd34, "marchid");
    expect_csr(CSR_MHARTID, 32'h0, "mhartid");
    csr_read(CSR_MARCHID, rsp);
    check_bit(rsp.rdonly, 1'b1, "marchid read-only");
    csr_read(CSR_MVENDORID, rsp);
    check_bit(rsp.rdonly, 1'b1, "mvendorid read-only");
    csr_read(CSR_MSCRATCH, rsp);
    check_bit(rsp.rdonly, 1'b0, "mscratch writable");
    csr_read(12'h7c0, rsp);
    check_bit(rsp.exists, 1'b0, "unknown address");
endtask

task automatic trap_dispatch();
    word_t      pc_word;
    exception_t want;
    pc_word = 32'h0000_1a2c;
    csr_write(CSR_MIE, 32'h0);
    csr_write(CSR_MTVEC, VEC_BASE);
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    @(posedge clk);
    retire <= '{valid: 1'b1, trap: 1'b1, cause: 5'd11, pc: pc_word[31:1]};
    @(negedge clk);
    want.take   = 1'b1;
    want.is_irq = 1'b0;
    want.cause  = 5'd11;
    want.tvec   = VEC_BASE[31:2];
    check_exc(exc, want, "trap take");
    drive_idle();
    expect_csr(CSR_MEPC, pc_word, "mepc after trap");
    check_pc(ret_epc, pc_word[31:1], "ret_epc after trap");
    expect_csr(CSR_MCAUSE, 32'd11, "mcause after trap");
    // MIE off and the old MIE of 1 saved in MPIE.
    expect_csr(CSR_MSTATUS, 32'h0000_0080, "mstatus after trap");
endtask

task automatic irq_priority();
    word_t      rnd;
    irq_vec_t   lines;
    irq_vec_t   enabled;
    exception_t want;
    // Sparse mask, so pending but disabled lines sit below the winner.
    enabled = 32'h5a5a_0008;
    csr_write(CSR_MIE, enabled);
    for (int n = 0; n < RAND_ROUNDS; n++) begin
        rnd   = $random(seed);
        lines = '0;
        lines[31:EXT_IRQ_LO]  = rnd[31:16];
        lines[TIMER_IRQ_BIT]  = rnd[0] & rnd[1];
        // At least one enabled line pending.
        if ((lines & enabled) == '0)
            lines[TIMER_IRQ_BIT] = 1'b1;
        @(posedge clk);
        irq       <= lines[31:EXT_IRQ_LO];
        timer_irq <= lines[TIMER_IRQ_BIT];
        // Third cycle after the MIE write.
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        @(posedge clk);
        @(posedge clk);
        retire <= '{valid: 1'b1, trap: 1'b1, cause: 5'd2, pc: rnd[31:1]};
        @(negedge clk);
        want.take   = 1'b1;
        want.is_irq = 1'b1;
        want.cause  = lowest_cause(lines & enabled);
        want.tvec   = VEC_BASE[31:2];
        check_cause(exc.cause, want.cause, "lowest enabled cause");
        check_exc(exc, want, "interrupt beats trap");
        drive_idle();
        irq       <= '0;
        timer_irq <= 1'b0;
    end
    // Only the timer enabled while external lines are pending.
    csr_write(CSR_MIE, 32'h0000_0008);
    @(posedge clk);
    irq <= 16'hffff;
    csr_write(CSR_MSTATUS, 32'h0000_0008);
    @(posedge clk);
    @(posedge clk);
    retire <= '{valid: 1'b1, trap: 1'b1, cause: 5'd2, pc: 31'h0000_0200};
    @(negedge clk);
    want.take   = 1'b1;
    want.is_irq = 1'b0;
    want.cause  = 5'd2;
    want.tvec   = VEC_BASE[31:2];
    check_exc(exc, want, "trap with no enabled interrupt");
    drive_idle();
    irq <= '0;
endtask

task automatic enable_delay();
    irq_vec_t   lines;
    irq_vec_t   enabled;
    exception_t want;
    lines = '0;
    lines[17:16] = 2'b11;
    lines[TIMER_IRQ_BIT] = 1'b1;
    enabled = 32'h0001_0008;
    csr_write(CSR_MSTATUS, 32'h0);
    csr_write(CSR_MIE, enabled);
    @(posedge clk);
    irq       <= lines[31:EXT_IRQ_LO];
    timer_irq <= 1'b1;
    // Line 17 is pending but masked off.
    expect_csr(CSR_MIP, lines & enabled, "mip masked by mie");
    // Write cycle with a plain instruction retiring from here on.
    @(posedge clk);
    csr_req <= '{we: 1'b1, addr: CSR_MSTATUS, wdata: 32'h0000_0008};
    retire  <= '{valid: 1'b1, trap: 1'b0, cause: 5'd0, pc: 31'h0000_0100};
    @(negedge clk);
    check_bit(exc.take, 1'b0, "take in the MIE write cycle");
    @(posedge clk);
    csr_req <= '0;
    @(negedge clk);
    check_bit(exc.take, 1'b0, "take in the first cycle after the write");
    @(posedge clk);
    @(negedge clk);
    check_bit(exc.take, 1'b0, "take in the second cycle after the write");
    @(posedge clk);
    @(negedge clk);
    want.take   = 1'b1;
    want.is_irq = 1'b1;
    want.cause  = lowest_cause(lines & enabled);
    want.tvec   = VEC_BASE[31:2];
    check_exc(exc, want, "take in the third cycle after the write");
    drive_idle();
    irq       <= '0;
    timer_irq <= 1'b0;
endtask

task automatic mret_return();
    word_t epc_word;
    epc_word = 32'h0000_4444;
    csr_write(CSR_MIE, 32'h0);
    csr_write(CSR_MEPC, epc_word);
    // MIE clear and MPIE set.
    csr_write(CSR_MSTATUS, 32'h0000_0080);
    @(posedge clk);
    mret_valid <= 1'b1;
    csr_req    <= '{we: 1'b1, addr: CSR_MSCRATCH, wdata: 32'h0bad_f00d};
    @(negedge clk);
    check_bit(mret_stall, 1'b1, "mret_stall with CSR write");
    check_bit(ret_pulse, 1'b0, "ret_pulse while stalled");
    @(posedge clk);
    csr_req <= '0;
    @(negedge clk);
    check_bit(mret_stall, 1'b0, "mret_stall without CSR write");
    check_bit(ret_pulse, 1'b1, "ret_pulse without CSR write");
    check_pc(ret_epc, epc_word[31:1], "ret_epc at MRET");
    drive_idle();
    expect_csr(CSR_MSTATUS, 32'h0000_0088, "MIE restored from MPIE");
    expect_csr(CSR_MSCRATCH, 32'h0bad_f00d, "write during stalled MRET");
endtask

`endif

// ==== tb_trap_unit.sv ====
// Trap unit testbench: clock, reset, DUT, watchdog and the directed test sequence.
`default_nettype none
`timescale 1ns/10ps

module tb_trap_unit import csr_pkg::*, trap_pkg::*; ();

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int RAND_ROUNDS   = 12;

    // Trap vector used by every test after setup.
    localparam word_t VEC_BASE = 32'h0000_2000;

    // Rough cycle counts of each test, they size the watchdog.
    localparam int CSR_CYCLES   = 40;
    localparam int TRAP_CYCLES  = 20;
    localparam int PRIO_CYCLES  = RAND_ROUNDS * 8 + 20;
    localparam int DELAY_CYCLES = 24;
    localparam int MRET_CYCLES  = 20;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 4 + CSR_CYCLES + TRAP_CYCLES
                                + PRIO_CYCLES + DELAY_CYCLES + MRET_CYCLES;

    logic                 clk;
    logic                 rst;
    csr_req_t             csr_req;
    csr_rsp_t             csr_rsp;
    retire_t              retire;
    logic                 mret_valid;
    logic [31:EXT_IRQ_LO] irq;
    logic                 timer_irq;
    exception_t           exc;
    logic                 ret_pulse;
    pc_t                  ret_epc;
    logic                 mret_stall;

    // Seed for the random interrupt patterns.
    integer seed;

    `include "tb_trap_unit_tasks.svh"

    // Default parameters: hart 0, C and M present, enable delay of 2.
    trap_unit_top UUT (
        .clk        (clk),
        .rst        (rst),
        .csr_req    (csr_req),
        .csr_rsp    (csr_rsp),
        .retire     (retire),
        .mret_valid (mret_valid),
        .irq        (irq),
        .timer_irq  (timer_irq),
        .exc        (exc),
        .ret_pulse  (ret_pulse),
        .ret_epc    (ret_epc),
        .mret_stall (mret_stall)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // Twice the expected length of all tests.
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD_NS * 2);
        stop_run("watchdog expired before the tests finished");
    end

    initial begin
        seed       = 32'h6d0e_62e1;
        clk        = 1'b0;
        rst        = 1'b1;
        csr_req    = '0;
        retire     = '0;
        mret_valid = 1'b0;
        irq        = '0;
        timer_irq  = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Outputs quiet and CSRs cleared after reset.
        @(negedge clk);
        check_bit(exc.take, 1'b0, "take after reset");
        check_bit(ret_pulse, 1'b0, "ret_pulse after reset");
        check_bit(mret_stall, 1'b0, "mret_stall after reset");
        expect_csr(CSR_MSTATUS, 32'h0, "mstatus after reset");
        expect_csr(CSR_MEPC, 32'h0, "mepc after reset");

        csr_access();
        trap_dispatch();
        irq_priority();
        enable_delay();
        mret_return();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== trap_unit_top.sv ====
// Trap unit top: machine CSR file, interrupt prioritizer and trap control.
`default_nettype none
`timescale 1ns/10ps

module trap_unit_top import csr_pkg::*, trap_pkg::*; #(
    parameter word_t hartid           = 32'h0,
    parameter bit    has_c            = 1'b1,
    parameter bit    has_m            = 1'b1,
    parameter int    irq_enable_delay = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire csr_req_t             csr_req,
    output      csr_rsp_t             csr_rsp,
    input  wire retire_t              retire,
    input  wire logic                 mret_valid,
    input  wire logic [31:EXT_IRQ_LO] irq,
    input  wire logic                 timer_irq,
    output      exception_t           exc,
    output      logic                 ret_pulse,
    output      pc_t                  ret_epc,
    output      logic                 mret_stall
);

    // Prioritizer to control.
    logic     irq_pending;
    cause_t   irq_cause;
    logic     irq_en;

    // CSR file to the other two blocks.
    irq_vec_t pending;
    irq_vec_t mie_mask;
    logic     mstatus_mie;
    tvec_t    mtvec;

    csr_file #(
        .hartid (hartid),
        .has_c  (has_c),
        .has_m  (has_m)
    ) u_csr_file (
        .clk         (clk),
        .rst         (rst),
        .csr_req     (csr_req),
        .csr_rsp     (csr_rsp),
        .exc         (exc),
        .trap_pc     (retire.pc),
        .ret_pulse   (ret_pulse),
        .pending     (pending),
        .mie_mask    (mie_mask),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (ret_epc)
    );

    irq_prioritizer #(
        .irq_enable_delay (irq_enable_delay)
    ) u_irq_prioritizer (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .timer_irq   (timer_irq),
        .mie_mask    (mie_mask),
        .mstatus_mie (mstatus_mie),
        .pending     (pending),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_en      (irq_en)
    );

    trap_control u_trap_control (
        .retire      (retire),
        .mret_valid  (mret_valid),
        .csr_we      (csr_req.we),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_en      (irq_en),
        .mtvec       (mtvec),
        .exc         (exc),
        .ret_pulse   (ret_pulse),
        .mret_stall  (mret_stall)
    );

endmodule

`default_nettype wire

// ==== trap_control.sv ====
// Trap control: dispatches an interrupt ahead of a trap and qualifies MRET completion.
`default_nettype none
`timescale 1ns/10ps

module trap_control import trap_pkg::*; (
    input  wire retire_t    retire,
    input  wire logic       mret_valid,
    input  wire logic       csr_we,
    input  wire logic       irq_pending,
    input  wire cause_t     irq_cause,
    input  wire logic       irq_en,
    input  wire tvec_t      mtvec,
    output      exception_t exc,
    output      logic       ret_pulse,
    output      logic       mret_stall
);

    // Interrupt may only land on a valid retiring instruction.
    logic irq_take;

    always_comb begin
        irq_take = irq_pending && irq_en && retire.valid;

        // Every take goes through the single mtvec entry.
        exc.tvec = mtvec;

        if (irq_take) begin
            // Interrupt wins over any trap of the same instruction.
            exc.take   = 1'b1;
            exc.is_irq = 1'b1;
            exc.cause  = irq_cause;
        end else if (retire.trap) begin
            // Synchronous trap from write-back.
            exc.take   = 1'b1;
            exc.is_irq = 1'b0;
            exc.cause  = retire.cause;
        end else begin
            exc.take   = 1'b0;
            exc.is_irq = 1'b0;
            exc.cause  = '0;
        end

        // MRET reads mstatus and mepc.
        // A write in flight must land first.
        mret_stall = mret_valid && csr_we;

        // A take flushes the MRET along with the rest of the pipe.
        ret_pulse = mret_valid && !mret_stall && !exc.take;

        a_stall_excludes_ret: assert (!(mret_stall && ret_pulse));
    end

endmodule

`default_nettype wire

// ==== irq_prioritizer.sv ====
// Interrupt prioritizer: latches lines, masks with mie, picks the lowest cause, delays enable.
`default_nettype none
`timescale 1ns/10ps

module irq_prioritizer import trap_pkg::*; #(
    // Edges that mstatus.mie must have been set for, at least 1.
    parameter int irq_enable_delay = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [31:EXT_IRQ_LO] irq,
    input  wire logic                 timer_irq,
    input  wire irq_vec_t             mie_mask,
    input  wire logic                 mstatus_mie,
    output      irq_vec_t             pending,
    output      logic                 irq_pending,
    output      cause_t               irq_cause,
    output      logic                 irq_en
);

    irq_vec_t                    masked;
    logic [irq_enable_delay-1:0] mie_hist;

    // Pending lines, one cycle behind the pins.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending                 <= '0;
            pending[31:EXT_IRQ_LO]  <= irq;
            pending[TIMER_IRQ_BIT]  <= timer_irq;
        end
    end

    assign masked = pending & mie_mask;

    // Cause 0 is not an interrupt, so bit 0 is left out.
    assign irq_pending = |masked[31:1];

    // Lowest set index wins, so scan from the top down.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 1; i--) begin
            if (masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // History of mstatus.mie over the last edges.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist[0] <= mstatus_mie;
            for (int i = 1; i < irq_enable_delay; i++) begin
                mie_hist[i] <= mie_hist[i-1];
            end
        end
    end

    // The live bit closes the gap right after a take clears MIE.
    assign irq_en = (&mie_hist) && mstatus_mie;

    a_cause_is_masked: assert property (
        @(posedge clk) disable iff (rst) irq_pending |-> masked[irq_cause]
    );

endmodule

`default_nettype wire

// ==== csr_file.sv ====
// Machine CSR file: storage, read decode, CSR writes and trap and return state updates.
`default_nettype none
`timescale 1ns/10ps

module csr_file import csr_pkg::*, trap_pkg::*; #(
    // Value read from mhartid.
    parameter word_t hartid = 32'h0,
    // Compressed extension present.
    parameter bit    has_c  = 1'b1,
    // Multiply extension present.
    parameter bit    has_m  = 1'b1
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire csr_req_t   csr_req,
    output      csr_rsp_t   csr_rsp,
    input  wire exception_t exc,
    // PC of the retiring instruction, saved into mepc on a take.
    input  wire pc_t        trap_pc,
    input  wire logic       ret_pulse,
    input  wire irq_vec_t   pending,
    output      irq_vec_t   mie_mask,
    output      logic       mstatus_mie,
    output      tvec_t      mtvec,
    output      pc_t        mepc
);

    // Stored state.
    logic     mstatus_mpie;
    irq_vec_t mie;
    word_t    mscratch;
    logic     mcause_irq;
    cause_t   mcause_no;

    // Assembled read views.
    word_t mstatus_word;
    word_t misa_word;
    word_t mcause_word;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_word[MSTATUS_MPIE_BIT] = mstatus_mpie;
    end

    // MXL=1 for RV32, base I always present.
    always_comb begin
        misa_word = '0;
        misa_word[31:30] = 2'b01;
        misa_word[12]    = has_m;
        misa_word[8]     = 1'b1;
        misa_word[2]     = has_c;
    end

    assign mcause_word = {mcause_irq, 26'b0, mcause_no};

    // Read decode, answered in the request cycle.
    always_comb begin
        csr_rsp.exists = 1'b1;
        csr_rsp.rdonly = 1'b0;
        csr_rsp.rdata  = '0;
        case (csr_req.addr)
            CSR_MSTATUS:  csr_rsp.rdata = mstatus_word;
            CSR_MISA:     csr_rsp.rdata = misa_word;
            CSR_MEDELEG:  csr_rsp.rdata = '0;
            CSR_MIDELEG:  csr_rsp.rdata = '0;
            CSR_MIE:      csr_rsp.rdata = mie;
            CSR_MTVEC:    csr_rsp.rdata = {mtvec, 2'b00};
            CSR_MSTATUSH: csr_rsp.rdata = '0;
            // Only enabled lines show as pending.
            CSR_MIP:      csr_rsp.rdata = pending & mie;
            CSR_MSCRATCH: csr_rsp.rdata = mscratch;
            CSR_MEPC:     csr_rsp.rdata = {mepc, 1'b0};
            CSR_MCAUSE:   csr_rsp.rdata = mcause_word;
            CSR_MTVAL:    csr_rsp.rdata = '0;
            CSR_MVENDORID, CSR_MIMPID, CSR_MCONFIGPTR: begin
                csr_rsp.rdonly = 1'b1;
            end
            CSR_MARCHID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = MARCHID_VALUE;
            end
            CSR_MHARTID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = hartid;
            end
            default: begin
                // Unknown address.
                csr_rsp.exists = 1'b0;
            end
        endcase
    end

    // Trap beats CSR write, CSR write beats MRET.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_irq   <= 1'b0;
            mcause_no    <= '0;
        end else if (exc.take) begin
            // Enter the handler with interrupts off.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= trap_pc;
            mcause_irq   <= exc.is_irq;
            mcause_no    <= exc.cause;
        end else if (csr_req.we) begin
            case (csr_req.addr)
                CSR_MSTATUS: begin
                    mstatus_mie  <= csr_req.wdata[MSTATUS_MIE_BIT];
                    mstatus_mpie <= csr_req.wdata[MSTATUS_MPIE_BIT];
                end
                CSR_MIE:      mie      <= csr_req.wdata;
                CSR_MTVEC:    mtvec    <= csr_req.wdata[31:2];
                CSR_MSCRATCH: mscratch <= csr_req.wdata;
                CSR_MEPC:     mepc     <= csr_req.wdata[31:1];
                CSR_MCAUSE: begin
                    mcause_irq <= csr_req.wdata[31];
                    mcause_no  <= csr_req.wdata[4:0];
                end
                // Read-only and fixed registers ignore writes.
                default: ;
            endcase
        end else if (ret_pulse) begin
            // MRET restores the saved enable.
            mstatus_mie <= mstatus_mpie;
        end
    end

    assign mie_mask = mie;

    // Control must never take a trap and complete an MRET in one cycle.
    a_take_excludes_ret: assert property (
        @(posedge clk) disable iff (rst) !(exc.take && ret_pulse)
    );

endmodule

`default_nettype wire

// ==== trap_pkg.sv ====
// Trap package: cause, PC, vector and interrupt types plus the retire and exception structs.
`default_nettype none

package trap_pkg;

    // Interrupt or trap number.
    typedef logic [4:0] cause_t;

    // Halfword-aligned PC, bit 0 is implied zero.
    typedef logic [31:1] pc_t;

    // Word-aligned trap vector, bits 1 to 0 are implied zero.
    typedef logic [31:2] tvec_t;

    // Pending or enable mask, one bit per cause.
    typedef logic [31:0] irq_vec_t;

    // Machine timer interrupt cause.
    localparam int TIMER_IRQ_BIT = 3;
    // First of the 16 external lines.
    localparam int EXT_IRQ_LO    = 16;

    // Instruction leaving write-back.
    typedef struct packed {
        logic   valid;
        logic   trap;
        cause_t cause;
        pc_t    pc;
    } retire_t;

    // Taken exception, either an interrupt or a trap.
    typedef struct packed {
        logic   take;
        logic   is_irq;
        cause_t cause;
        tvec_t  tvec;
    } exception_t;

endpackage

`default_nettype wire

// ==== csr_pkg.sv ====
// CSR package: machine CSR addresses, word types and the CSR request and response structs.
`default_nettype none

package csr_pkg;

    // Plain 32-bit CSR or data word.
    typedef logic [31:0] word_t;

    // 12-bit CSR address.
    typedef logic [11:0] csr_addr_t;

    // Machine trap setup.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;

    // Machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;

    // Machine identity, all read-only.
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Bit positions inside mstatus.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Architecture ID reported in marchid.
    localparam word_t MARCHID_VALUE = 32'd34;

    // CSR access request, a plain strobe with no handshake.
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        word_t     wdata;
    } csr_req_t;

    // Combinational answer to a request.
    // Rdonly is only meaningful when exists is set.
    typedef struct packed {
        logic  exists;
        logic  rdonly;
        word_t rdata;
    } csr_rsp_t;

endpackage

`default_nettype wire
